/* project.f */
+incdir+src
src/tcp_app_pkg.sv
src/app_control_regs.sv
src/echo_path.sv
src/udp_traffic_gen.sv
src/tcp_app_top.sv
verif/tb_checker.sv
verif/tb_top.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
TOP        = tb_top
RTL_TOP    = tcp_app_top
FILELIST   = project.f
OBJ_DIR    = obj_dir
PASS_MSG   = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_top.sv */
`include "tcp_app_config.svh"

module tb_top
  import tcp_app_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PKTS = 20;

  logic                              aclk;
  logic                              aresetn;
  logic [`TCP_APP_AXIL_ADDR_W-1:0]   s_axil_awaddr, s_axil_araddr;
  logic [`TCP_APP_AXIL_DATA_W-1:0]   s_axil_wdata, s_axil_rdata;
  logic [`TCP_APP_AXIL_DATA_W/8-1:0] s_axil_wstrb;
  logic [1:0]                        s_axil_bresp, s_axil_rresp;
  logic                              s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
  logic                              s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
  logic                              s_axil_rvalid, s_axil_rready;
  logic                              rx_meta_valid, rx_meta_ready, rx_data_valid, rx_data_ready;
  logic                              tx_meta_valid, tx_meta_ready, tx_data_valid, tx_data_ready;
  logic                              udp_meta_valid, udp_meta_ready, udp_data_valid, udp_data_ready;
  session_id_t                       rx_meta_data, tx_meta_data;
  logic [`TCP_APP_DATA_W-1:0]        rx_data_data, tx_data_data, udp_data_data;
  logic [`TCP_APP_KEEP_W-1:0]        rx_data_keep, tx_data_keep, udp_data_keep;
  logic                              rx_data_last, tx_data_last, udp_data_last;
  udp_meta_t                         udp_meta_data;
  logic                              mem0_calib_done, mem1_calib_done;

  int          pkt_len[NUM_PKTS];   // beats per echo packet
  session_id_t pkt_sess[NUM_PKTS];
  logic [7:0]  udp_pkts;
  logic [7:0]  udp_words;
  logic [7:0]  udp_gap;
  logic [31:0] local_ip_exp;         // shadow of the ip registers
  logic [31:0] target_ip_exp;
  logic [31:0] ctrl_val;
  int          planned;
  int          cycle_limit = 0;
  int          cycles = 0;

  tcp_app_top dut_i (.*);
  tb_checker chk_i (.*);

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;  // 25 MHz
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // about 30% back-pressure on every output stream
  initial begin
    tx_meta_ready = 1'b0;
    tx_data_ready = 1'b0;
    udp_meta_ready = 1'b0;
    udp_data_ready = 1'b0;
    forever begin
      @(posedge aclk);
      #2;
      tx_meta_ready = ($urandom % 10) >= 3;
      tx_data_ready = ($urandom % 10) >= 3;
      udp_meta_ready = ($urandom % 10) >= 3;
      udp_data_ready = ($urandom % 10) >= 3;
    end
  end

  task automatic step(input int n);
    repeat (n) @(posedge aclk);
    #2;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    s_axil_awaddr = addr;
    s_axil_wdata = data;
    s_axil_wstrb = 4'hF;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid = 1'b1;
    do @(negedge aclk); while (!s_axil_awready);  // aw and w go together
    step(1);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid = 1'b0;
    do @(negedge aclk); while (!s_axil_bvalid);
    step(1);
  endtask

  task automatic read_reg(input logic [3:0] addr, input logic [31:0] exp, input logic [31:0] mask);
    chk_i.expect_read(exp, mask);
    s_axil_araddr = addr;
    s_axil_arvalid = 1'b1;
    do @(negedge aclk); while (!s_axil_arready);
    step(1);
    s_axil_arvalid = 1'b0;
    do @(negedge aclk); while (!s_axil_rvalid);  // checker compares here
    step(1);
  endtask

  task automatic send_packet(input int p);
    rx_meta_data = pkt_sess[p];
    rx_meta_valid = 1'b1;
    do @(negedge aclk); while (!rx_meta_ready);
    step(1);
    rx_meta_valid = 1'b0;
    for (int b = 0; b < pkt_len[p]; b++) begin
      rx_data_valid = 1'b1;
      rx_data_data = {$urandom, $urandom};
      rx_data_last = (b == pkt_len[p] - 1);
      do @(negedge aclk); while (!rx_data_ready);
      step(1);
    end
    rx_data_valid = 1'b0;
    rx_data_last = 1'b0;
  endtask

  initial begin
    void'($urandom(92));
    s_axil_awaddr = '0;
    s_axil_araddr = '0;
    s_axil_wdata = '0;
    s_axil_wstrb = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid = 1'b0;
    s_axil_arvalid = 1'b0;
    s_axil_bready = 1'b1;  // responses always taken
    s_axil_rready = 1'b1;
    rx_meta_valid = 1'b0;
    rx_meta_data = '0;
    rx_data_valid = 1'b0;
    rx_data_data = '0;
    rx_data_keep = '1;
    rx_data_last = 1'b0;
    mem0_calib_done = 1'b0;
    mem1_calib_done = 1'b0;
    planned = 0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      pkt_len[p] = 1 + int'($urandom % 8);
      pkt_sess[p] = 16'($urandom);
      planned += pkt_len[p];
    end
    udp_pkts = 8'(1 + $urandom % 4);
    udp_words = 8'($urandom % 7);
    udp_gap = 8'($urandom % 6);
    planned += int'(udp_pkts) * ((udp_words == 8'd0 ? 1 : int'(udp_words)) + int'(udp_gap));
    cycle_limit = 4 * planned + 500;
    aresetn = 1'b0;
    repeat (2) @(posedge aclk);
    #2;
    aresetn = 1'b1;

    chk_i.begin_test("registers");
    read_reg(`TCP_APP_REG_LOCAL_IP, 32'h0B03A8C0, '1);
    read_reg(`TCP_APP_REG_TARGET_IP, 32'h0A03A8C0, '1);
    local_ip_exp = $urandom;
    target_ip_exp = $urandom;
    write_reg(`TCP_APP_REG_LOCAL_IP, local_ip_exp);
    write_reg(`TCP_APP_REG_TARGET_IP, target_ip_exp);
    ctrl_val = $urandom;
    ctrl_val[31:24] = 8'd0;  // zero packets so the run bit starts nothing
    ctrl_val[0] = 1'b1;
    write_reg(`TCP_APP_REG_CTRL, ctrl_val);
    read_reg(`TCP_APP_REG_LOCAL_IP, local_ip_exp, '1);
    read_reg(`TCP_APP_REG_TARGET_IP, target_ip_exp, '1);
    read_reg(`TCP_APP_REG_CTRL, ctrl_val & ~32'h1, '1);
    read_reg(4'h2, 32'h0, '1);  // unmapped
    chk_i.finish_test();

    chk_i.begin_test("echo data");
    for (int p = 0; p < NUM_PKTS; p++) send_packet(p);
    chk_i.finish_test();

    chk_i.begin_test("echo count");
    read_reg(`TCP_APP_REG_STATUS, 32'(NUM_PKTS) << 16, 32'hFFFF_0000);
    chk_i.finish_test();

    chk_i.begin_test("udp run");
    chk_i.expect_udp(udp_pkts, udp_words, local_ip_exp, target_ip_exp);
    write_reg(`TCP_APP_REG_CTRL, {udp_pkts, udp_gap, udp_words, 7'd0, 1'b1});
    while (chk_i.udp_pending() != 0) @(negedge aclk);
    step(20);  // room for any stray packet after the last beat
    read_reg(`TCP_APP_REG_STATUS, 32'h0, 32'h2);
    chk_i.finish_test();

    chk_i.begin_test("memory ready");
    read_reg(`TCP_APP_REG_STATUS, 32'h0, 32'h1);
    mem0_calib_done = 1'b1;
    step(5);
    read_reg(`TCP_APP_REG_STATUS, 32'h0, 32'h1);
    mem0_calib_done = 1'b0;
    mem1_calib_done = 1'b1;
    step(5);
    read_reg(`TCP_APP_REG_STATUS, 32'h0, 32'h1);
    mem0_calib_done = 1'b1;
    step(5);
    read_reg(`TCP_APP_REG_STATUS, 32'h1, 32'h1);
    chk_i.finish_test();

    chk_i.report_totals();
    if (chk_i.total_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* verif/tb_checker.sv */
`include "tcp_app_config.svh"

module tb_checker
  import tcp_app_pkg::*;
(
  input logic                             aclk,
  input logic                             s_axil_bvalid, s_axil_bready,
  input logic [1:0]                       s_axil_bresp, s_axil_rresp,
  input logic                             s_axil_rvalid, s_axil_rready,
  input logic [`TCP_APP_AXIL_DATA_W-1:0]  s_axil_rdata,
  input logic                             rx_meta_valid, rx_meta_ready,
  input logic                             rx_data_valid, rx_data_ready,
  input session_id_t                      rx_meta_data, tx_meta_data,
  input logic [`TCP_APP_DATA_W-1:0]       rx_data_data, tx_data_data, udp_data_data,
  input logic                             rx_data_last, tx_data_last, udp_data_last,
  input logic [`TCP_APP_KEEP_W-1:0]       tx_data_keep, udp_data_keep,
  input logic                             tx_meta_valid, tx_meta_ready,
  input logic                             tx_data_valid, tx_data_ready,
  input logic                             udp_meta_valid, udp_meta_ready,
  input logic                             udp_data_valid, udp_data_ready,
  input udp_meta_t                        udp_meta_data
);
  timeunit 1ns;
  timeprecision 1ps;

  string       cur_test = "idle";
  int          test_errs;
  int          test_checks;
  int          total_errs;
  int          total_checks;
  int          tests_passed;
  int          tests_failed;
  logic [31:0] rd_exp_q[$];    // expected read words
  logic [31:0] rd_mask_q[$];   // bits that matter per read
  session_id_t sess_q[$];      // sessions taken on rx and owed on tx
  logic [64:0] echo_q[$];      // {last, data} of rx beats
  udp_meta_t   udp_meta_q[$];
  logic [64:0] udp_beat_q[$];  // {last, data} per udp beat
  logic        echo_open = 1'b0;  // tx meta out, beats may follow
  logic        udp_open = 1'b0;   // udp meta out, beats may follow

  task automatic note_error(input string msg);
    test_errs++;
    total_errs++;
    $display("ERROR in %s: %s", cur_test, msg);
  endtask

  task automatic compare(input string what, input logic [111:0] exp, input logic [111:0] act);
    test_checks++;
    total_checks++;
    if (exp !== act) begin
      test_errs++;
      total_errs++;
      $display("FAILED %s: %s expected %0h actual %0h", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errs = 0;
    test_checks = 0;
  endtask

  task automatic expect_read(input logic [31:0] exp, input logic [31:0] mask);
    rd_exp_q.push_back(exp);
    rd_mask_q.push_back(mask);
  endtask

  // one meta then max(words,1) beats per packet with the beat index as payload
  task automatic expect_udp(input logic [7:0] pkts, input logic [7:0] words,
                            input logic [31:0] src, input logic [31:0] dst);
    logic [7:0] beats;
    udp_meta_t  m;
    beats = (words == 8'd0) ? 8'd1 : words;
    m.src_ip = src;
    m.dst_ip = dst;
    m.src_port = `TCP_APP_UDP_SRC_PORT;
    m.dst_port = `TCP_APP_UDP_DST_PORT;
    m.length = 16'(beats) * 16'd8;  // bytes
    for (int p = 0; p < int'(pkts); p++) begin
      udp_meta_q.push_back(m);
      for (int i = 0; i < int'(beats); i++) udp_beat_q.push_back({i == int'(beats) - 1, 64'(i)});
    end
  endtask

  function automatic int udp_pending();
    return udp_meta_q.size() + udp_beat_q.size();
  endfunction

  task automatic finish_test();
    int left;
    left = rd_exp_q.size() + sess_q.size() + echo_q.size() + udp_pending();
    if (left != 0) note_error($sformatf("%0d expected items were never seen", left));
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: passed, %0d checks", cur_test, test_checks);
    end else begin
      tests_failed++;
      $display("test %s: failed, %0d errors", cur_test, test_errs);
    end
    cur_test = "idle";
  endtask

  task automatic report_totals();
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, total_checks, total_errs);
  endtask

  // sampled mid-cycle while inputs are stable
  always @(negedge aclk) begin : monitor
    logic [31:0] rd_exp;
    logic [31:0] rd_mask;
    if (s_axil_bvalid && s_axil_bready) begin
      compare("write resp", 112'(2'b00), 112'(s_axil_bresp));
    end
    if (s_axil_rvalid && s_axil_rready) begin
      compare("read resp", 112'(2'b00), 112'(s_axil_rresp));
      if (rd_exp_q.size() == 0) begin
        note_error("read data came back with no read outstanding");
      end else begin
        rd_exp = rd_exp_q.pop_front();
        rd_mask = rd_mask_q.pop_front();
        compare("read data", 112'(rd_exp & rd_mask), 112'(s_axil_rdata & rd_mask));
      end
    end
    // rx side first since a tx beat can pass in the same cycle
    if (rx_meta_valid && rx_meta_ready) sess_q.push_back(rx_meta_data);
    if (rx_data_valid && rx_data_ready) echo_q.push_back({rx_data_last, rx_data_data});
    if (tx_meta_valid && tx_meta_ready) begin
      if (echo_open) note_error("tx meta sent before the previous packet ended");
      echo_open = 1'b1;
      if (sess_q.size() == 0) note_error("tx meta sent with no session received");
      else compare("tx session", 112'(sess_q.pop_front()), 112'(tx_meta_data));
    end
    if (tx_data_valid && tx_data_ready) begin
      if (!echo_open) note_error("tx beat sent ahead of its meta");
      if (tx_data_last) echo_open = 1'b0;
      if (echo_q.size() == 0) note_error("tx beat sent with no rx beat behind it");
      else compare("tx {last,data}", 112'(echo_q.pop_front()),
                   112'({tx_data_last, tx_data_data}));
      compare("tx keep", 112'(8'hFF), 112'(tx_data_keep));
    end
    if (udp_meta_valid && udp_meta_ready) begin
      if (udp_open) note_error("udp meta sent before the previous packet ended");
      udp_open = 1'b1;
      if (udp_meta_q.size() == 0) note_error("udp meta sent that no run asked for");
      else compare("udp meta", udp_meta_q.pop_front(), udp_meta_data);
    end
    if (udp_data_valid && udp_data_ready) begin
      if (!udp_open) note_error("udp beat sent ahead of its meta");
      if (udp_data_last) udp_open = 1'b0;
      if (udp_beat_q.size() == 0) note_error("udp beat sent that no run asked for");
      else compare("udp {last,data}", 112'(udp_beat_q.pop_front()),
                   112'({udp_data_last, udp_data_data}));
      compare("udp keep", 112'(8'hFF), 112'(udp_data_keep));
    end
  end

endmodule

/* src/tcp_app_top.sv */
`include "tcp_app_config.svh"

module tcp_app_top
  import tcp_app_pkg::*;
(
  input  logic                               aclk,
  input  logic                               aresetn,
  // control bus
  input  logic [`TCP_APP_AXIL_ADDR_W-1:0]    s_axil_awaddr,
  input  logic                               s_axil_awvalid,
  output logic                               s_axil_awready,
  input  logic [`TCP_APP_AXIL_DATA_W-1:0]    s_axil_wdata,
  input  logic [`TCP_APP_AXIL_DATA_W/8-1:0]  s_axil_wstrb,
  input  logic                               s_axil_wvalid,
  output logic                               s_axil_wready,
  output logic [1:0]                         s_axil_bresp,
  output logic                               s_axil_bvalid,
  input  logic                               s_axil_bready,
  input  logic [`TCP_APP_AXIL_ADDR_W-1:0]    s_axil_araddr,
  input  logic                               s_axil_arvalid,
  output logic                               s_axil_arready,
  output logic [`TCP_APP_AXIL_DATA_W-1:0]    s_axil_rdata,
  output logic [1:0]                         s_axil_rresp,
  output logic                               s_axil_rvalid,
  input  logic                               s_axil_rready,
  // echo in from the stack
  input  logic                               rx_meta_valid,
  output logic                               rx_meta_ready,
  input  session_id_t                        rx_meta_data,
  input  logic                               rx_data_valid,
  output logic                               rx_data_ready,
  input  logic [`TCP_APP_DATA_W-1:0]         rx_data_data,
  input  logic [`TCP_APP_KEEP_W-1:0]         rx_data_keep,
  input  logic                               rx_data_last,
  // echo out to the stack
  output logic                               tx_meta_valid,
  input  logic                               tx_meta_ready,
  output session_id_t                        tx_meta_data,
  output logic                               tx_data_valid,
  input  logic                               tx_data_ready,
  output logic [`TCP_APP_DATA_W-1:0]         tx_data_data,
  output logic [`TCP_APP_KEEP_W-1:0]         tx_data_keep,
  output logic                               tx_data_last,
  // udp generator out
  output logic                               udp_meta_valid,
  input  logic                               udp_meta_ready,
  output udp_meta_t                          udp_meta_data,
  output logic                               udp_data_valid,
  input  logic                               udp_data_ready,
  output logic [`TCP_APP_DATA_W-1:0]         udp_data_data,
  output logic [`TCP_APP_KEEP_W-1:0]         udp_data_keep,
  output logic                               udp_data_last,
  input  logic                               mem0_calib_done,
  input  logic                               mem1_calib_done
);

  logic             udp_start;
  logic             udp_busy;
  logic             echo_done;
  udp_ctrl_fields_t udp_ctrl;
  logic [31:0]      local_ip;
  logic [31:0]      target_ip;

  app_control_regs ctrl_regs_i (
    .aclk, .aresetn,
    .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
    .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
    .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
    .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
    .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
    .mem0_calib_done, .mem1_calib_done,
    .echo_done, .udp_busy, .udp_start, .udp_ctrl,
    .local_ip, .target_ip
  );

  echo_path echo_i (
    .aclk, .aresetn,
    .rx_meta_valid, .rx_meta_ready, .rx_meta_data,
    .rx_data_valid, .rx_data_ready, .rx_data_data, .rx_data_keep, .rx_data_last,
    .tx_meta_valid, .tx_meta_ready, .tx_meta_data,
    .tx_data_valid, .tx_data_ready, .tx_data_data, .tx_data_keep, .tx_data_last,
    .echo_done
  );

  udp_traffic_gen udp_gen_i (
    .aclk, .aresetn,
    .udp_start, .udp_ctrl, .local_ip, .target_ip, .udp_busy,
    .udp_meta_valid, .udp_meta_ready, .udp_meta_data,
    .udp_data_valid, .udp_data_ready, .udp_data_data, .udp_data_keep, .udp_data_last
  );

endmodule

/* src/udp_traffic_gen.sv */
`include "tcp_app_config.svh"

module udp_traffic_gen
  import tcp_app_pkg::*;
(
  input  logic                         aclk,
  input  logic                         aresetn,
  input  logic                         udp_start,
  input  udp_ctrl_fields_t             udp_ctrl,
  input  logic [31:0]                  local_ip,
  input  logic [31:0]                  target_ip,
  output logic                         udp_busy,
  output logic                         udp_meta_valid,
  input  logic                         udp_meta_ready,
  output udp_meta_t                    udp_meta_data,
  output logic                         udp_data_valid,
  input  logic                         udp_data_ready,
  output logic [`TCP_APP_DATA_W-1:0]   udp_data_data,
  output logic [`TCP_APP_KEEP_W-1:0]   udp_data_keep,
  output logic                         udp_data_last
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_META = 2'd1;  // one meta per packet
  localparam logic [1:0] ST_DATA = 2'd2;
  localparam logic [1:0] ST_GAP  = 2'd3;  // idle between packets

  logic [1:0] state;
  logic [7:0] pkt_left;    // packets still to send, incl current
  logic [7:0] beat_cnt;    // beat index in packet
  logic [7:0] gap_cnt;
  logic [7:0] beats_q;     // latched beats per packet
  logic [7:0] gap_q;       // latched gap
  logic [7:0] start_beats;
  udp_meta_t  meta_q;
  logic       data_hs;

  assign start_beats = (udp_ctrl.word_count == 8'd0) ? 8'd1 : udp_ctrl.word_count;  // min one beat

  assign udp_busy = (state != ST_IDLE);
  assign udp_meta_valid = (state == ST_META);
  assign udp_meta_data = meta_q;
  assign udp_data_valid = (state == ST_DATA);
  assign udp_data_data = {{(`TCP_APP_DATA_W-8){1'b0}}, beat_cnt};  // payload is beat index
  assign udp_data_keep = '1;
  assign udp_data_last = (beat_cnt == beats_q - 8'd1);
  assign data_hs = udp_data_valid && udp_data_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= ST_IDLE;
      pkt_left <= '0;
      beat_cnt <= '0;
      gap_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (udp_start && udp_ctrl.packet_count != 8'd0) begin  // zero packets is a no-op
            pkt_left <= udp_ctrl.packet_count;
            state <= ST_META;
          end
        end
        ST_META: begin
          beat_cnt <= '0;
          if (udp_meta_ready) state <= ST_DATA;
        end
        ST_DATA: begin
          if (data_hs) begin
            beat_cnt <= beat_cnt + 8'd1;
            if (udp_data_last) begin
              pkt_left <= pkt_left - 8'd1;
              gap_cnt <= gap_q;
              if (pkt_left == 8'd1) state <= ST_IDLE;  // run finished
              else if (gap_q == 8'd0) state <= ST_META;
              else state <= ST_GAP;
            end
          end
        end
        ST_GAP: begin
          gap_cnt <= gap_cnt - 8'd1;
          if (gap_cnt == 8'd1) state <= ST_META;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // settings and header fixed for the whole run
  always_ff @(posedge aclk) begin
    if (udp_start && state == ST_IDLE) begin
      beats_q <= start_beats;
      gap_q <= udp_ctrl.packet_gap;
      meta_q.src_ip <= local_ip;
      meta_q.dst_ip <= target_ip;
      meta_q.src_port <= `TCP_APP_UDP_SRC_PORT;
      meta_q.dst_port <= `TCP_APP_UDP_DST_PORT;
      meta_q.length <= {5'd0, start_beats, 3'd0};  // beats * 8 bytes
    end
  end

endmodule

/* src/echo_path.sv */
`include "tcp_app_config.svh"

module echo_path
  import tcp_app_pkg::*;
(
  input  logic                         aclk,
  input  logic                         aresetn,
  input  logic                         rx_meta_valid,
  output logic                         rx_meta_ready,
  input  session_id_t                  rx_meta_data,
  input  logic                         rx_data_valid,
  output logic                         rx_data_ready,
  input  logic [`TCP_APP_DATA_W-1:0]   rx_data_data,
  input  logic [`TCP_APP_KEEP_W-1:0]   rx_data_keep,
  input  logic                         rx_data_last,
  output logic                         tx_meta_valid,
  input  logic                         tx_meta_ready,
  output session_id_t                  tx_meta_data,
  output logic                         tx_data_valid,
  input  logic                         tx_data_ready,
  output logic [`TCP_APP_DATA_W-1:0]   tx_data_data,
  output logic [`TCP_APP_KEEP_W-1:0]   tx_data_keep,
  output logic                         tx_data_last,
  output logic                         echo_done
);

  localparam logic [1:0] ST_IDLE = 2'd0;  // waiting for rx meta
  localparam logic [1:0] ST_META = 2'd1;  // presenting tx meta
  localparam logic [1:0] ST_DATA = 2'd2;  // beats flow through

  logic [1:0]  state;
  session_id_t session_q;
  logic        beat_hs;

  assign rx_meta_ready = (state == ST_IDLE);
  assign tx_meta_valid = (state == ST_META);
  assign tx_meta_data = session_q;

  // data only passes once the meta has gone out
  assign tx_data_valid = rx_data_valid && (state == ST_DATA);
  assign rx_data_ready = tx_data_ready && (state == ST_DATA);
  assign tx_data_data = rx_data_data;
  assign tx_data_keep = rx_data_keep;
  assign tx_data_last = rx_data_last;

  assign beat_hs = tx_data_valid && tx_data_ready;
  assign echo_done = beat_hs && rx_data_last;  // one per packet

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (rx_meta_valid) state <= ST_META;
        ST_META: if (tx_meta_ready) state <= ST_DATA;
        ST_DATA: if (echo_done) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (rx_meta_valid && rx_meta_ready) session_q <= rx_meta_data;  // held for tx meta
  end

endmodule

/* src/app_control_regs.sv */
`include "tcp_app_config.svh"

module app_control_regs
  import tcp_app_pkg::*;
(
  input  logic                               aclk,
  input  logic                               aresetn,
  input  logic [`TCP_APP_AXIL_ADDR_W-1:0]    s_axil_awaddr,
  input  logic                               s_axil_awvalid,
  output logic                               s_axil_awready,
  input  logic [`TCP_APP_AXIL_DATA_W-1:0]    s_axil_wdata,
  input  logic [`TCP_APP_AXIL_DATA_W/8-1:0]  s_axil_wstrb,
  input  logic                               s_axil_wvalid,
  output logic                               s_axil_wready,
  output logic [1:0]                         s_axil_bresp,
  output logic                               s_axil_bvalid,
  input  logic                               s_axil_bready,
  input  logic [`TCP_APP_AXIL_ADDR_W-1:0]    s_axil_araddr,
  input  logic                               s_axil_arvalid,
  output logic                               s_axil_arready,
  output logic [`TCP_APP_AXIL_DATA_W-1:0]    s_axil_rdata,
  output logic [1:0]                         s_axil_rresp,
  output logic                               s_axil_rvalid,
  input  logic                               s_axil_rready,
  input  logic                               mem0_calib_done,  // async
  input  logic                               mem1_calib_done,  // async
  input  logic                               echo_done,
  input  logic                               udp_busy,
  output logic                               udp_start,
  output udp_ctrl_fields_t                   udp_ctrl,
  output logic [31:0]                        local_ip,
  output logic [31:0]                        target_ip
);

  udp_ctrl_u   ctrl_q;       // stored settings, run always 0
  udp_ctrl_u   wr_word;      // incoming write data as fields
  logic        wr_hs;
  logic        rd_hs;
  logic [31:0] rd_word;
  logic        c0_r1, c0_r2;
  logic        c1_r1, c1_r2;
  logic        mem_ready;
  logic [15:0] echo_cnt;

  // byte-lane merge for wstrb
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

  assign wr_word.raw = s_axil_wdata;
  assign wr_hs = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;  // no response pending
  assign rd_hs = s_axil_arvalid && !s_axil_rvalid;
  assign s_axil_awready = wr_hs;  // aw and w taken together
  assign s_axil_wready = wr_hs;
  assign s_axil_arready = rd_hs;
  assign s_axil_bresp = 2'b00;    // always OKAY
  assign s_axil_rresp = 2'b00;
  assign udp_ctrl = ctrl_q.fields;
  assign mem_ready = c0_r2 & c1_r2;

  // write channel and register file
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ctrl_q.raw <= '0;
      local_ip <= `TCP_APP_DEFAULT_LOCAL_IP;
      target_ip <= `TCP_APP_DEFAULT_TARGET_IP;
      udp_start <= 1'b0;
      s_axil_bvalid <= 1'b0;
    end else begin
      // start only on a run write while the generator is idle
      udp_start <= wr_hs && (s_axil_awaddr == `TCP_APP_REG_CTRL) && s_axil_wstrb[0] &&
                   wr_word.fields.run && !udp_busy;
      if (wr_hs) begin
        s_axil_bvalid <= 1'b1;
        case (s_axil_awaddr)
          `TCP_APP_REG_CTRL: begin
            ctrl_q.raw <= merge_bytes(ctrl_q.raw, s_axil_wdata, s_axil_wstrb);
            ctrl_q.fields.run <= 1'b0;  // trigger bit not kept
          end
          `TCP_APP_REG_LOCAL_IP: local_ip <= merge_bytes(local_ip, s_axil_wdata, s_axil_wstrb);
          `TCP_APP_REG_TARGET_IP: target_ip <= merge_bytes(target_ip, s_axil_wdata, s_axil_wstrb);
          default: ;  // status is read only
        endcase
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
    end
  end

  // read mux, unmapped reads zero
  always_comb begin
    case (s_axil_araddr)
      `TCP_APP_REG_CTRL: rd_word = ctrl_q.raw;
      `TCP_APP_REG_LOCAL_IP: rd_word = local_ip;
      `TCP_APP_REG_TARGET_IP: rd_word = target_ip;
      `TCP_APP_REG_STATUS: rd_word = {echo_cnt, 14'd0, udp_busy, mem_ready};
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_rvalid <= 1'b0;
    end else if (rd_hs) begin
      s_axil_rvalid <= 1'b1;
    end else if (s_axil_rready) begin
      s_axil_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_hs) s_axil_rdata <= rd_word;  // held until rready
  end

  // two-flop sync of calibration flags, then echo packet count
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      c0_r1 <= 1'b0;
      c0_r2 <= 1'b0;
      c1_r1 <= 1'b0;
      c1_r2 <= 1'b0;
      echo_cnt <= '0;
    end else begin
      c0_r1 <= mem0_calib_done;
      c0_r2 <= c0_r1;
      c1_r1 <= mem1_calib_done;
      c1_r2 <= c1_r1;
      if (echo_done) echo_cnt <= echo_cnt + 16'd1;  // wraps
    end
  end

endmodule

/* src/tcp_app_pkg.sv */
`include "tcp_app_config.svh"

package tcp_app_pkg;

  typedef logic [`TCP_APP_SESSION_W-1:0] session_id_t;  // tcp session handle

  // udp tx metadata, 112 bits
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;     // bytes
  } udp_meta_t;

  // control register fields
  typedef struct packed {
    logic [7:0] packet_count;  // packets per run
    logic [7:0] packet_gap;    // idle cycles between packets
    logic [7:0] word_count;    // beats per packet, 0 treated as 1
    logic [6:0] reserved;
    logic       run;           // write-only trigger
  } udp_ctrl_fields_t;

  // bus view and field view of the same word
  typedef union packed {
    logic [31:0]      raw;
    udp_ctrl_fields_t fields;
  } udp_ctrl_u;

endpackage

/* src/tcp_app_config.svh */
`ifndef TCP_APP_CONFIG_SVH
`define TCP_APP_CONFIG_SVH

// stream widths
`define TCP_APP_DATA_W 64      // one word per beat
`define TCP_APP_KEEP_W 8       // byte enables
`define TCP_APP_SESSION_W 16   // tcp session id

// control bus
`define TCP_APP_AXIL_ADDR_W 4
`define TCP_APP_AXIL_DATA_W 32

// register map, byte offsets
`define TCP_APP_REG_CTRL 4'h0       // generator settings and run
`define TCP_APP_REG_LOCAL_IP 4'h4
`define TCP_APP_REG_TARGET_IP 4'h8
`define TCP_APP_REG_STATUS 4'hC     // mem ready, busy, echo count

// reset addresses, byte-swapped as the stack expects
`define TCP_APP_DEFAULT_LOCAL_IP 32'h0B03A8C0   // 192.168.3.11
`define TCP_APP_DEFAULT_TARGET_IP 32'h0A03A8C0  // 192.168.3.10

// fixed iperf ports
`define TCP_APP_UDP_SRC_PORT 16'd5001
`define TCP_APP_UDP_DST_PORT 16'd5001

`endif
